// File: filelist.f
logic/stream_pkg.sv
logic/cfg_pkg.sv
logic/apb_regs.sv
logic/skid_buffer.sv
logic/piso_flex.sv
logic/width_adapter_top.sv
bench/width_adapter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the width adapter testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module width_adapter_tb -f filelist.f -o width_adapter_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/width_adapter_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// File: bench/width_adapter_tb.sv
`timescale 1ns/10ps

module width_adapter_tb;

  import stream_pkg::*;
  import cfg_pkg::*;

  localparam int WORDS_PER_LANE = 20;                // chunk splitting words per lane.
  localparam int PKTS_LAST      = 3;                 // packets per lane in the last flag test.
  localparam int PKTS_FLOW      = 4;                 // packets per lane in the flow control test.
  localparam int MAX_PKT_LEN    = 4;                 // packets are 1 to 4 words.
  localparam int BEATS_PER_SET  = 8 + 4 + 2 + 1;     // one word at every lane code.
  localparam int MAX_WORDS      = WORDS_PER_LANE + (PKTS_LAST + PKTS_FLOW) * MAX_PKT_LEN;
  localparam int MAX_BEATS      = BEATS_PER_SET * MAX_WORDS;
  localparam int CYCLE_LIMIT    = 4 * MAX_BEATS + 500;
  localparam logic [31:0] SEED  = 32'd99892;

  logic        CLK = 1'b0;
  logic        RST_N;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        in_valid;
  logic        in_ready;
  in_beat_t    in_beat;
  logic        out_valid;
  logic        out_ready;
  out_beat_t   out_beat;

  out_beat_t   exp_q[$];                             // expected output beats in order.
  out_beat_t   exp_beat;
  lane_code_t  lane_now;                             // lane code the DUT holds.
  logic [31:0] stim_lfsr = SEED;                     // data, gaps and lengths.
  logic        gap_en;                               // random in_valid gaps.
  logic        stall_en;                             // random out_ready stalls.
  int          errors;
  int          cmp_errors;
  int          beats_seen;
  int          beats_total;
  int          words_sent;
  int          cycles;

  width_adapter_top dut0 (
    .CLK(CLK), .RST_N(RST_N),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
    .out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat)
  );

  always #20 CLK = ~CLK;                             // 40 ns period.

  // galois lfsr for x^32 + x^22 + x^2 + x + 1 stepped once per bit.
  function automatic logic lfsr_step(inout logic [31:0] st);
    logic b;
    b  = st[0];
    st = st >> 1;
    if (b) begin
      st = st ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [63:0] take_bits(inout logic [31:0] st, input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_step(st)};                  // one step per bit taken.
    end
    return r;
  endfunction

  // expected beat idx of a word built bit by bit from the lane width.
  function automatic out_beat_t ref_chunk(input word_t w, input logic last,
                                          input lane_code_t lane, input int idx);
    out_beat_t b;
    int        width;
    width  = 8 << lane;                              // 8, 16, 32 or 64 bits.
    b.data = '0;                                     // upper bits stay zero.
    for (int i = 0; i < width; i++) begin
      b.data[i] = w[idx * width + i];
    end
    b.last = last && (idx == (64 / width) - 1);      // final chunk only.
    return b;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
    assert (got == want) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  // one full apb transfer that starts and ends 2 ns after a rising edge.
  task automatic apb_access(input apb_addr_t addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;                                  // setup phase.
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge CLK);
    #2;
    penable = 1'b1;                                  // access phase.
    @(negedge CLK);
    rdata = prdata;                                  // stable mid access.
    err   = pslverr;
    check_value(32'(pready), 32'd1, "pready in access phase");
    @(posedge CLK);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
    apb_access(addr, 1'b0, 32'd0, data, err);
  endtask

  // present one word and queue its expected chunks.
  task automatic send_word(input word_t w, input logic last);
    int n;
    n = 64 / (8 << lane_now);
    if (gap_en) begin
      repeat (int'(take_bits(stim_lfsr, 1))) begin
        @(posedge CLK);
        #2;
      end
    end
    in_valid     = 1'b1;
    in_beat.data = w;
    in_beat.last = last;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(ref_chunk(w, last, lane_now, i));
    end
    words_sent++;
    beats_total += n;
    @(negedge CLK);
    while (!in_ready) begin
      @(negedge CLK);                                // handshake lands on the next edge.
    end
    @(posedge CLK);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic send_packet(input int len);
    for (int i = 0; i < len; i++) begin
      send_word(take_bits(stim_lfsr, 64), i == len - 1);
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge CLK);
      #2;
    end
  endtask

  // lane changes only with the pipeline idle.
  task automatic set_lane(input lane_code_t code);
    logic err;
    drain();
    apb_write(ADDR_CTRL, {30'd0, code}, err);
    check_value(32'(err), 32'd0, "pslverr on lane write");
    lane_now = code;
  endtask

  // out_ready stalls drawn from a separate lfsr state.
  initial begin
    logic [31:0] stall_lfsr;
    stall_lfsr = SEED;
    out_ready  = 1'b1;
    forever begin
      @(posedge CLK);
      #2;
      out_ready = stall_en ? (take_bits(stall_lfsr, 2) != 64'd0) : 1'b1; // stall one in four.
    end
  end

  // comparator sampled mid cycle ahead of the handshake edge.
  always @(negedge CLK) begin
    if (RST_N && out_valid && out_ready) begin
      beats_seen++;
      assert (exp_q.size() > 0) else begin
        cmp_errors++;
        $display("CHECK FAILED at %0t: output beat with nothing expected", $time);
      end
      if (exp_q.size() > 0) begin
        exp_beat = exp_q.pop_front();
        assert (out_beat == exp_beat) else begin
          cmp_errors++;
          $display("CHECK FAILED at %0t: beat %0d got %h/%b expected %h/%b", $time, beats_seen,
                   out_beat.data, out_beat.last, exp_beat.data, exp_beat.last);
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d  beats checked: %0d", errors + cmp_errors, beats_seen);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    RST_N    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    in_valid = 1'b0;
    in_beat  = '0;
    gap_en   = 1'b0;
    stall_en = 1'b0;
    lane_now = LANE_64;
    repeat (4) @(posedge CLK);
    #2;
    RST_N = 1'b1;

    // reset state.
    check_value(32'(out_valid), 32'd0, "out_valid after reset");
    apb_read(ADDR_CTRL, rd, err);
    check_value(rd, 32'd3, "lane after reset");
    apb_read(ADDR_WORDS, rd, err);
    check_value(rd, 32'd0, "words after reset");
    apb_read(ADDR_BEATS, rd, err);
    check_value(rd, 32'd0, "beats after reset");

    // chunk splitting at every lane code.
    for (int l = 0; l < 4; l++) begin
      set_lane(lane_code_t'(l));
      for (int i = 0; i < WORDS_PER_LANE; i++) begin
        send_word(take_bits(stim_lfsr, 64), 1'b0);
      end
    end

    // last flag on packets of random length.
    for (int l = 0; l < 4; l++) begin
      set_lane(lane_code_t'(l));
      repeat (PKTS_LAST) send_packet(int'(take_bits(stim_lfsr, 2)) + 1);
    end

    // flow control with gaps and stalls.
    gap_en   = 1'b1;
    stall_en = 1'b1;
    for (int l = 0; l < 4; l++) begin
      set_lane(lane_code_t'(l ^ 2));                 // order 2, 3, 0, 1.
      repeat (PKTS_FLOW) send_packet(int'(take_bits(stim_lfsr, 2)) + 1);
    end
    drain();
    gap_en   = 1'b0;
    stall_en = 1'b0;
    repeat (8) @(posedge CLK);                       // any extra beat would show up here.
    #2;
    check_value(32'(out_valid), 32'd0, "out_valid once idle");
    check_value(32'(beats_seen), 32'(beats_total), "beats delivered");

    // counters, soft clear and unmapped offset.
    apb_read(ADDR_WORDS, rd, err);
    check_value(rd, 32'(words_sent % 65536), "words counter");
    apb_read(ADDR_BEATS, rd, err);
    check_value(rd, 32'(beats_total % 65536), "beats counter");
    apb_write(ADDR_CTRL, 32'h100 | {30'd0, lane_now}, err); // clear with the lane kept.
    apb_read(ADDR_WORDS, rd, err);
    check_value(rd, 32'd0, "words after clear");
    apb_read(ADDR_BEATS, rd, err);
    check_value(rd, 32'd0, "beats after clear");
    apb_read(ADDR_CTRL, rd, err);
    check_value(rd, {30'd0, lane_now}, "ctrl after clear");
    apb_read(4'hC, rd, err);
    check_value(32'(err), 32'd1, "pslverr at 0xC");
    check_value(rd, 32'd0, "read data at 0xC");

    $display("errors: %0d  beats checked: %0d", errors + cmp_errors, beats_seen);
    if (errors + cmp_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: logic/width_adapter_top.sv
`timescale 1ns/10ps

module width_adapter_top (
  input  logic                  CLK,
  input  logic                  RST_N,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  cfg_pkg::apb_addr_t    paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  stream_pkg::in_beat_t  in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output stream_pkg::out_beat_t out_beat
);

  import stream_pkg::*;
  import cfg_pkg::*;

  logic       ing_valid;                        // ingress to serializer.
  logic       ing_ready;
  in_beat_t   ing_beat;
  logic       ser_valid;                        // serializer to egress.
  logic       ser_ready;
  out_beat_t  ser_beat;
  lane_code_t lane;
  logic       flush;
  logic       word_taken;
  logic       beat_given;

  assign word_taken = in_valid & in_ready;      // counted at the input port.
  assign beat_given = out_valid & out_ready;    // counted at the output port.

  apb_regs u_regs (
    .CLK(CLK), .RST_N(RST_N),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .word_taken(word_taken), .beat_given(beat_given),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .lane(lane), .flush(flush)
  );

  skid_buffer #(.WIDTH(IN_BEAT_W)) u_ingress (
    .CLK(CLK), .RST_N(RST_N),
    .s_valid(in_valid), .s_data(in_beat), .s_ready(in_ready),
    .m_valid(ing_valid), .m_data(ing_beat), .m_ready(ing_ready)
  );

  piso_flex u_piso (
    .CLK(CLK), .RST_N(RST_N), .flush(flush), .lane(lane),
    .in_valid(ing_valid), .in_beat(ing_beat), .in_ready(ing_ready),
    .out_valid(ser_valid), .out_beat(ser_beat), .out_ready(ser_ready)
  );

  skid_buffer #(.WIDTH(OUT_BEAT_W)) u_egress (
    .CLK(CLK), .RST_N(RST_N),
    .s_valid(ser_valid), .s_data(ser_beat), .s_ready(ser_ready),
    .m_valid(out_valid), .m_data(out_beat), .m_ready(out_ready)
  );

endmodule

// File: logic/piso_flex.sv
`timescale 1ns/10ps

module piso_flex (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  logic                 flush,           // resets the chunk counter.
  input  cfg_pkg::lane_code_t  lane,
  input  logic                 in_valid,
  input  stream_pkg::in_beat_t in_beat,
  output logic                 in_ready,
  output logic                 out_valid,
  output stream_pkg::out_beat_t out_beat,
  input  logic                 out_ready
);

  import stream_pkg::*;
  import cfg_pkg::*;

  logic [2:0] cnt;                              // chunk index within the word.
  lane_code_t lane_q;                           // lane held for the word in progress.
  lane_code_t lane_cur;                         // lane in force for this chunk.
  logic [2:0] last_idx;                         // index of the final chunk.
  logic [5:0] offset;                           // bit position of the chunk.
  word_t      mask;                             // keeps the chunk width only.
  word_t      shifted;
  logic       final_chunk;
  logic       out_fire;

  assign lane_cur = (cnt == 3'd0) ? lane : lane_q; // sampled at the first chunk.

  // chunk geometry for the active lane.
  always_comb begin
    case (lane_cur)
      LANE_8: begin
        last_idx = 3'd7;
        offset   = {cnt, 3'b000};               // cnt times 8.
        mask     = 64'h0000_0000_0000_00ff;
      end
      LANE_16: begin
        last_idx = 3'd3;
        offset   = {cnt[1:0], 4'b0000};         // cnt times 16.
        mask     = 64'h0000_0000_0000_ffff;
      end
      LANE_32: begin
        last_idx = 3'd1;
        offset   = {cnt[0], 5'b00000};          // cnt times 32.
        mask     = 64'h0000_0000_ffff_ffff;
      end
      default: begin
        last_idx = 3'd0;                        // whole word in one beat.
        offset   = 6'd0;
        mask     = '1;
      end
    endcase
  end

  assign shifted     = in_beat.data >> offset;  // current chunk to the low bits.
  assign final_chunk = (cnt == last_idx);

  always_comb begin
    out_beat.data = shifted & mask;             // upper bits zero.
    out_beat.last = in_beat.last & final_chunk; // only on the last chunk.
  end

  assign out_valid = in_valid;
  assign in_ready  = out_ready & final_chunk;   // word retires with its last chunk.
  assign out_fire  = out_valid & out_ready;

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      cnt    <= 3'd0;
      lane_q <= LANE_RESET;
    end else if (flush) begin
      cnt    <= 3'd0;                           // next beat starts a new word.
    end else if (out_fire) begin
      if (cnt == 3'd0) begin
        lane_q <= lane;                         // hold the lane until the word ends.
      end
      cnt <= final_chunk ? 3'd0 : cnt + 3'd1;
    end
  end

endmodule

// File: logic/skid_buffer.sv
`timescale 1ns/10ps

module skid_buffer #(
  parameter int WIDTH = 8                       // payload bit count.
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             s_valid,
  input  logic [WIDTH-1:0] s_data,
  output logic             s_ready,
  output logic             m_valid,
  output logic [WIDTH-1:0] m_data,
  input  logic             m_ready
);

  logic             main_valid;                 // main register holds a beat.
  logic             ovf_valid;                  // overflow register holds a beat.
  logic [WIDTH-1:0] main_data;
  logic [WIDTH-1:0] ovf_data;
  logic             s_fire;                     // upstream transfer.
  logic             main_load;                  // main register is free this edge.

  assign s_ready   = ~ovf_valid;                // registered, no path from m_ready.
  assign m_valid   = main_valid;
  assign m_data    = main_data;
  assign s_fire    = s_valid & s_ready;
  assign main_load = ~main_valid | m_ready;     // empty or draining.

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      main_valid <= 1'b0;
      ovf_valid  <= 1'b0;
    end else if (main_load) begin
      main_valid <= ovf_valid | s_fire;         // overflow drains first.
      ovf_valid  <= 1'b0;
    end else if (s_fire) begin
      ovf_valid  <= 1'b1;                       // main stalled, park the beat.
    end
  end

  always_ff @(posedge CLK) begin
    if (main_load) begin
      main_data <= ovf_valid ? ovf_data : s_data; // keeps beat order.
    end
    if (!main_load && s_fire) begin
      ovf_data <= s_data;
    end
  end

endmodule

// File: logic/apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
  input  logic                CLK,
  input  logic                RST_N,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  cfg_pkg::apb_addr_t  paddr,
  input  logic [31:0]         pwdata,
  input  logic                word_taken,       // input handshake event.
  input  logic                beat_given,       // output handshake event.
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output cfg_pkg::lane_code_t lane,             // chunk width to serializer.
  output logic                flush             // one cycle soft clear.
);

  import cfg_pkg::*;

  logic       access;                           // access phase of a transfer.
  logic       addr_hit;                         // offset is in the map.
  logic       wr_ctrl;                          // write to the control register.
  lane_code_t lane_q;                           // stored lane code.
  count_t     words_q;                          // words accepted.
  count_t     beats_q;                          // beats delivered.

  assign access  = psel & penable;              // transfer completes here.
  assign pready  = 1'b1;                        // no wait states.
  assign pslverr = access & ~addr_hit;          // error on unmapped offset.

  assign wr_ctrl = access & pwrite & (paddr == ADDR_CTRL);

  // clear bit is never stored, so it pulses for the access cycle only.
  assign flush = wr_ctrl & pwdata[CTRL_CLEAR_BIT];

  assign lane = lane_q;

  // read mux, valid during the access phase.
  always_comb begin
    addr_hit = 1'b1;
    prdata   = '0;                              // unmapped reads return zero.
    case (paddr)
      ADDR_CTRL: begin
        prdata[1:0] = lane_q;                   // bit 8 reads as zero.
      end
      ADDR_WORDS: begin
        prdata[15:0] = words_q;                 // value before this increment.
      end
      ADDR_BEATS: begin
        prdata[15:0] = beats_q;
      end
      default: begin
        addr_hit = 1'b0;                        // flags pslverr.
      end
    endcase
  end

  // lane code register.
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      lane_q <= LANE_RESET;                     // 64-bit lane out of reset.
    end else if (wr_ctrl) begin
      lane_q <= pwdata[1:0];                    // takes effect on the access edge.
    end
  end

  // words accepted counter.
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      words_q <= '0;
    end else if (flush) begin
      words_q <= '0;                            // soft clear wins over an event.
    end else if (word_taken) begin
      words_q <= words_q + 16'd1;               // wraps at 65536.
    end
  end

  // beats delivered counter.
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      beats_q <= '0;
    end else if (flush) begin
      beats_q <= '0;
    end else if (beat_given) begin
      beats_q <= beats_q + 16'd1;               // wraps at 65536.
    end
  end

endmodule

// File: logic/cfg_pkg.sv
package cfg_pkg;

  typedef logic [1:0]  lane_code_t;               // chunk width select.
  typedef logic [15:0] count_t;                   // wrapping status counter.
  typedef logic [3:0]  apb_addr_t;                // register byte offset.

  // lane codes, chunks per word is 64 over the width.
  localparam lane_code_t LANE_8  = 2'd0;          // 8 chunks per word.
  localparam lane_code_t LANE_16 = 2'd1;          // 4 chunks per word.
  localparam lane_code_t LANE_32 = 2'd2;          // 2 chunks per word.
  localparam lane_code_t LANE_64 = 2'd3;          // word passes whole.

  localparam lane_code_t LANE_RESET = LANE_64;    // lane after reset.

  // register map.
  localparam apb_addr_t ADDR_CTRL  = 4'h0;        // lane code and soft clear.
  localparam apb_addr_t ADDR_WORDS = 4'h4;        // words accepted, read only.
  localparam apb_addr_t ADDR_BEATS = 4'h8;        // beats delivered, read only.

  localparam int CTRL_CLEAR_BIT = 8;              // soft clear, reads as zero.

endpackage

// File: logic/stream_pkg.sv
package stream_pkg;

  localparam int WORD_W = 64;                     // fixed input word width.

  typedef logic [WORD_W-1:0] word_t;              // one input data word.

  // beat on the input side, a full word per transfer.
  typedef struct packed {
    word_t data;                                  // payload word.
    logic  last;                                  // final word of a packet.
  } in_beat_t;

  // beat on the output side, one chunk per transfer.
  typedef struct packed {
    word_t data;                                  // chunk in low bits, rest zero.
    logic  last;                                  // final chunk of a last word.
  } out_beat_t;

  localparam int IN_BEAT_W  = $bits(in_beat_t);   // 65 bits.
  localparam int OUT_BEAT_W = $bits(out_beat_t);  // 65 bits.

endpackage
